//--- sim/mlpCases.txt
# columns 1 to 15: features 0 to 14, hex, two's complement
# columns 16 and 17: expected output 0 and output 1, hex
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 002f 0000
0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 001f 0055
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 000a 0000 0000 00db 0393
0000 0003 0000 0000 0000 0000 0000 0000 0000 0000 0002 0000 0000 0000 0000 01e0 0000
1000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 400b 0000
0000 0000 0000 0000 ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 006a 0000
0000 0000 0000 0000 0000 0000 0000 0002 0000 0000 0000 0001 0000 0000 0004 01f7 0000
0000 0000 0000 0000 0000 0000 fffe 0000 0000 0000 0000 0000 0000 0000 0000 0000 009d
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 01c8 0025
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0080 0000 0000 0000 0000 5f2c 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0000 0000 0000 0000 0000 0000
0000 0000 0000 8000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 7fe8

//--- sources.f
verilog/mlpPkg.sv
verilog/reluNeuron.sv
verilog/hiddenLayer.sv
verilog/outputLayer.sv
verilog/mlpBusSlave.sv
verilog/mlpTop.sv
sim/mlpBus_sva.sv
sim/mlpChecker.sv
sim/mlpTb.sv

//--- sim/mlpTb.sv
`default_nettype none

module mlpTb
	import mlpPkg::*;
();

	localparam int maxCases = 32;
	localparam int maxPolls = 16;
	localparam int ackLimit = 8;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [addrWidth-1:0] adr;
	logic [dataWidth-1:0] datIn;
	wire [dataWidth-1:0] datOut;
	wire ack;

	// each row holds the features followed by the two expected outputs
	logic [dataWidth-1:0] caseVec [maxCases][numFeatures+2];
	logic [dataWidth-1:0] expOut0;
	logic [dataWidth-1:0] expOut1;
	logic [dataWidth-1:0] rdData;
	int caseNum;
	int numCases;
	int tbErrors;
	int checkErrors;
	bit loaded;

	mlpTop UUT (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	mlpChecker uChecker (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.ack(ack),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.expOut0(expOut0),
		.expOut1(expOut1),
		.caseNum(caseNum),
		.errorCount(checkErrors)
	);

	bind mlpBusSlave mlpBusSva uBusSva (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.ack(ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic idleCycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// one classic cycle held until ack and dropped on the next edge
	task automatic busAccess(input logic write, input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] wdata);
		int waitCount;
		waitCount = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= addr;
		datIn <= wdata;
		@(negedge clk);
		while (!ack && waitCount < ackLimit)
		begin
			waitCount++;
			@(negedge clk);
		end
		if (!ack)
		begin
			$display("no ack for access to address %0d at time %0t", addr, $time);
			tbErrors++;
		end
		rdData = datOut;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		idleCycles($urandom % 4);
	endtask

	task automatic runCase(input int idx);
		int polls;
		caseNum = idx;
		expOut0 = caseVec[idx][numFeatures];
		expOut1 = caseVec[idx][numFeatures+1];
		for (int f = 0; f < numFeatures; f++)
			busAccess(1'b1, addrWidth'(addrFeatureBase + f), caseVec[idx][f]);
		// done has to read zero here
		busAccess(1'b0, addrStatus, '0);
		busAccess(1'b1, addrControl, dataWidth'(1) << ctrlStartBit);
		busAccess(1'b0, addrStatus, '0);
		polls = 1;
		while (!rdData[statDoneBit] && polls < maxPolls)
		begin
			busAccess(1'b0, addrStatus, '0);
			polls++;
		end
		if (!rdData[statDoneBit])
		begin
			$display("done flag never set in case %0d", idx);
			tbErrors++;
		end
		busAccess(1'b0, addrOutBase, '0);
		busAccess(1'b0, addrWidth'(addrOutBase + 1), '0);
		busAccess(1'b0, addrWidth'(addrFeatureBase + idx % numFeatures), '0);
		busAccess(1'b0, addrWidth'(addrFeatureBase + numFeatures - 1), '0);
		// holes in the map and the control register read as zero
		busAccess(1'b0, addrWidth'(addrFeatureBase + numFeatures), '0);
		busAccess(1'b0, addrControl, '0);
		busAccess(1'b0, addrWidth'(addrStatus + 1), '0);
		busAccess(1'b0, addrWidth'(addrOutBase + numOutputs + idx % 10), '0);
	endtask

	initial
	begin
		int fd;
		int n;
		int errTotal;
		string line;
		logic [dataWidth-1:0] v [numFeatures+2];
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		expOut0 = '0;
		expOut1 = '0;
		caseNum = 0;
		numCases = 0;
		tbErrors = 0;
		loaded = 1'b0;
		void'($urandom(92));

		fd = $fopen("sim/mlpCases.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open sim/mlpCases.txt");
			tbErrors++;
		end
		while (fd != 0 && !$feof(fd) && numCases < maxCases)
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#")
			begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
					v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
				if (n == numFeatures + 2)
				begin
					caseVec[numCases] = v;
					numCases++;
				end
				else
				begin
					$display("malformed line in sim/mlpCases.txt: %s", line);
					tbErrors++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		loaded = 1'b1;

		repeat (2) @(posedge clk);
		// a request held during reset must be neither acked nor stored
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= addrFeatureBase;
		datIn <= '1;
		repeat (2) @(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		@(posedge clk);
		reset <= 1'b0;

		if (numCases == 0)
		begin
			$display("no test cases were loaded");
			tbErrors++;
		end
		else
		begin
			// with zero features the outputs settle to the bias path
			idleCycles(inferLatency);
			expOut0 = caseVec[0][numFeatures];
			expOut1 = caseVec[0][numFeatures+1];
			busAccess(1'b0, addrOutBase, '0);
			busAccess(1'b0, addrWidth'(addrOutBase + 1), '0);
			for (int c = 0; c < numCases; c++)
				runCase(c);
		end
		idleCycles(2);

		errTotal = tbErrors + checkErrors + UUT.uBus.uBusSva.failCount;
		$display("cases run %0d, errors %0d", numCases, errTotal);
		if (errTotal == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog allows 200 cycles per case
	initial
	begin
		wait (loaded);
		repeat (numCases * 200 + 50) @(posedge clk);
		$display("run timed out, the test sequence did not finish");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/mlpChecker.sv
`default_nettype none

module mlpChecker
	import mlpPkg::*;
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire ack,
	input wire [addrWidth-1:0] adr,
	input wire [dataWidth-1:0] datIn,
	input wire [dataWidth-1:0] datOut,
	input wire [dataWidth-1:0] expOut0,
	input wire [dataWidth-1:0] expOut1,
	input int caseNum,
	output int errorCount
);

	logic [dataWidth-1:0] featureModel [numFeatures];
	bit startPending;
	int edgesSinceStart;

	task automatic compare(input string what, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t: case %0d %s read %h, expected %h",
				$time, caseNum, what, got, exp);
		end
	endtask

	task automatic checkAccess();
		int offset;
		logic [dataWidth-1:0] statusExp;
		offset = int'(adr) - int'(addrFeatureBase);
		// done shows on a read acked after the fourth edge past the start ack
		statusExp = '0;
		statusExp[statDoneBit] = startPending && edgesSinceStart >= inferLatency + 1;
		if (we)
		begin
			if (offset >= 0 && offset < numFeatures)
			begin
				featureModel[offset] = datIn;
				startPending = 1'b0;
			end
			else if (adr == addrControl && datIn[ctrlStartBit])
			begin
				startPending = 1'b1;
				edgesSinceStart = 0;
			end
		end
		else if (offset >= 0 && offset < numFeatures)
			compare($sformatf("feature %0d", offset), datOut, featureModel[offset]);
		else if (adr == addrStatus)
			compare("status", datOut, statusExp);
		else if (adr == addrOutBase)
			compare("output 0", datOut, expOut0);
		else if (adr == addrOutBase + 1)
			compare("output 1", datOut, expOut1);
		else
			compare($sformatf("unmapped address %0d", adr), datOut, '0);
	endtask

	// ack, address and read data are all settled at the falling edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			errorCount = 0;
			startPending = 1'b0;
			edgesSinceStart = 0;
			for (int i = 0; i < numFeatures; i++)
				featureModel[i] = '0;
		end
		else
		begin
			if (startPending)
				edgesSinceStart++;
			if (ack && cyc && stb)
				checkAccess();
		end
	end

endmodule

`default_nettype wire

//--- sim/mlpBus_sva.sv
`default_nettype none

module mlpBusSva
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire ack
);

	int failCount = 0;

	// one ack per request
	singleAck: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
	else
	begin
		failCount++;
		$error("ack stayed high on two consecutive cycles");
	end

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb))
	else
	begin
		failCount++;
		$error("ack rose without a cyc and stb request");
	end

	ackLowInReset: assert property (@(posedge clk) reset |=> !ack)
	else
	begin
		failCount++;
		$error("ack was high while reset was applied");
	end

endmodule

`default_nettype wire

//--- verilog/mlpTop.sv
`default_nettype none

module mlpTop
	import mlpPkg::*;
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [addrWidth-1:0] adr,
	input wire [dataWidth-1:0] datIn,
	output wire [dataWidth-1:0] datOut,
	output wire ack
);

	wire [numFeatures*dataWidth-1:0] features;
	wire [numHidden*dataWidth-1:0] hiddenAct;
	wire [numOutputs*dataWidth-1:0] outAct;

	// host registers, start and done tracking
	mlpBusSlave uBus (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.features(features),
		.outAct(outAct)
	);

	hiddenLayer uHidden (
		.clk(clk),
		.reset(reset),
		.features(features),
		.hiddenAct(hiddenAct)
	);

	// results go back to the bus slave for reads
	outputLayer uOutput (
		.clk(clk),
		.reset(reset),
		.hiddenAct(hiddenAct),
		.outAct(outAct)
	);

endmodule

`default_nettype wire

//--- verilog/mlpBusSlave.sv
`default_nettype none

module mlpBusSlave
	import mlpPkg::*;
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [addrWidth-1:0] adr,
	input wire [dataWidth-1:0] datIn,
	output logic [dataWidth-1:0] datOut,
	output logic ack,
	output logic [numFeatures*dataWidth-1:0] features,
	input wire [numOutputs*dataWidth-1:0] outAct
);

	logic [dataWidth-1:0] featureReg [numFeatures];

	logic request;
	logic writeEn;
	logic [addrWidth-1:0] featureOffset;
	logic [addrWidth-1:0] outOffset;
	logic isFeature;
	logic isControl;
	logic isStatus;
	logic isOut;
	logic featureWrite;
	logic startReq;

	logic [countWidth-1:0] countdown;
	logic done;
	logic [dataWidth-1:0] readData;

	// a request is new only while it has not been acked yet
	assign request = cyc && stb && !ack;
	assign writeEn = request && we;

	// offsets wrap below the base, so one compare covers both bounds
	assign featureOffset = adr - addrFeatureBase;
	assign outOffset = adr - addrOutBase;

	assign isFeature = featureOffset < numFeatures;
	assign isControl = adr == addrControl;
	assign isStatus = adr == addrStatus;
	assign isOut = outOffset < numOutputs;

	assign featureWrite = writeEn && isFeature;
	assign startReq = writeEn && isControl && datIn[ctrlStartBit];

	// single-cycle ack, no wait states
	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= request;
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < numFeatures; i++)
		begin
			if (reset)
				featureReg[i] <= '0;
			else if (featureWrite && featureOffset[featureIdxWidth-1:0] == i)
				featureReg[i] <= datIn;
		end
	end

	always_comb
	begin
		for (int i = 0; i < numFeatures; i++)
			features[i*dataWidth +: dataWidth] = featureReg[i];
	end

	// done follows inferLatency edges after the start ack
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			countdown <= '0;
			done <= 1'b0;
		end
		else if (startReq)
		begin
			countdown <= countWidth'(inferLatency);
			done <= 1'b0;
		end
		else if (featureWrite)
		begin
			// new features make any pending result stale
			countdown <= '0;
			done <= 1'b0;
		end
		else if (countdown != '0)
		begin
			countdown <= countdown - 1'b1;
			if (countdown == countWidth'(1))
				done <= 1'b1;
		end
	end

	// control reads as zero, unmapped too
	always_comb
	begin
		readData = '0;
		if (isFeature)
			readData = featureReg[featureOffset[featureIdxWidth-1:0]];
		else if (isStatus)
			readData[statDoneBit] = done;
		else if (isOut)
			readData = outAct[outOffset[outIdxWidth-1:0]*dataWidth +: dataWidth];
	end

	// read data lands with the ack
	always_ff @(posedge clk)
	begin
		if (request && !we)
			datOut <= readData;
	end

endmodule

`default_nettype wire

//--- verilog/outputLayer.sv
`default_nettype none

module outputLayer
	import mlpPkg::*;
(
	input wire clk,
	input wire reset,
	input wire [numHidden*dataWidth-1:0] hiddenAct,
	output logic [numOutputs*dataWidth-1:0] outAct
);

	logic [dataWidth-1:0] neuronAct [numOutputs];

	// same neuron pipeline, fed by the hidden activations
	generate
		for (genvar o = 0; o < numOutputs; o++)
		begin : gNeuron
			reluNeuron #(
				.numInputs(numHidden),
				.rowIndex(o),
				.isOutput(1'b1)
			) uNeuron (
				.clk(clk),
				.reset(reset),
				.inVec(hiddenAct),
				.act(neuronAct[o])
			);
		end
	endgenerate

	// output 0 in the low word
	always_comb
	begin
		for (int o = 0; o < numOutputs; o++)
			outAct[o*dataWidth +: dataWidth] = neuronAct[o];
	end

endmodule

`default_nettype wire

//--- verilog/hiddenLayer.sv
`default_nettype none

module hiddenLayer
	import mlpPkg::*;
(
	input wire clk,
	input wire reset,
	input wire [numFeatures*dataWidth-1:0] features,
	output logic [numHidden*dataWidth-1:0] hiddenAct
);

	logic [dataWidth-1:0] neuronAct [numHidden];

	// every hidden neuron sees the whole feature vector
	generate
		for (genvar h = 0; h < numHidden; h++)
		begin : gNeuron
			reluNeuron #(
				.numInputs(numFeatures),
				.rowIndex(h),
				.isOutput(1'b0)
			) uNeuron (
				.clk(clk),
				.reset(reset),
				.inVec(features),
				.act(neuronAct[h])
			);
		end
	endgenerate

	// pack neuron outputs, neuron 0 in the low word
	always_comb
	begin
		for (int h = 0; h < numHidden; h++)
			hiddenAct[h*dataWidth +: dataWidth] = neuronAct[h];
	end

endmodule

`default_nettype wire

//--- verilog/reluNeuron.sv
`default_nettype none

module reluNeuron
	import mlpPkg::*;
#(
	parameter int numInputs = numFeatures,
	parameter int rowIndex = 0,
	parameter bit isOutput = 1'b0
)
(
	input wire clk,
	input wire reset,
	input wire [numInputs*dataWidth-1:0] inVec,
	output logic [dataWidth-1:0] act
);

	logic [dataWidth-1:0] weight [numInputs];
	logic [dataWidth-1:0] bias;
	logic [dataWidth-1:0] inReg [numInputs];
	logic [dataWidth-1:0] sum;

	// pick the weight row from the table of the layer this neuron sits in
	generate
		if (isOutput)
		begin : gOutRow
			for (genvar i = 0; i < numInputs; i++)
			begin : gWeight
				assign weight[i] = outWeights[rowIndex][i];
			end
			assign bias = outBias[rowIndex];
		end
		else
		begin : gHiddenRow
			for (genvar i = 0; i < numInputs; i++)
			begin : gWeight
				assign weight[i] = hiddenWeights[rowIndex][i];
			end
			assign bias = hiddenBias[rowIndex];
		end
	endgenerate

	// stage 1, capture the input vector
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < numInputs; i++)
		begin
			if (reset)
				inReg[i] <= '0;
			else
				inReg[i] <= inVec[i*dataWidth +: dataWidth];
		end
	end

	// products and sum wrap at 16 bits
	always_comb
	begin
		logic [dataWidth-1:0] acc;
		acc = bias;
		for (int i = 0; i < numInputs; i++)
			acc = acc + inReg[i] * weight[i];
		sum = acc;
	end

	// stage 2, ReLU on the sign bit
	always_ff @(posedge clk)
	begin
		if (reset)
			act <= '0;
		else if (sum[dataWidth-1])
			act <= '0;
		else
			act <= sum;
	end

endmodule

`default_nettype wire

//--- verilog/mlpPkg.sv
`default_nettype none

package mlpPkg;

	localparam int dataWidth = 16;
	localparam int numFeatures = 15;
	localparam int numHidden = 4;
	localparam int numOutputs = 2;
	localparam int addrWidth = 5;

	// index widths used when decoding bus addresses
	localparam int featureIdxWidth = $clog2(numFeatures);
	localparam int outIdxWidth = (numOutputs > 1) ? $clog2(numOutputs) : 1;

	// pipeline depth, input stage plus activation stage per layer
	localparam int neuronLatency = 2;
	localparam int inferLatency = 2 * neuronLatency;
	localparam int countWidth = $clog2(inferLatency + 1);

	// register map in word addresses
	localparam logic [addrWidth-1:0] addrFeatureBase = addrWidth'(0);
	localparam logic [addrWidth-1:0] addrControl = addrWidth'(16);
	localparam logic [addrWidth-1:0] addrStatus = addrWidth'(17);
	localparam logic [addrWidth-1:0] addrOutBase = addrWidth'(20);

	// control and status bit positions
	localparam int ctrlStartBit = 0;
	localparam int statDoneBit = 0;

	// hidden layer, one row per neuron and one column per feature
	localparam logic signed [dataWidth-1:0] hiddenWeights [numHidden][numFeatures] = '{
		'{ -4,   2,  22,  23, -16, -17,  -2,  -5,  -4,   3,  47,  34,  27, -35,  17},
		'{ 11,  -9,   6,  -3,  14,   8, -21,  19,   5, -12,   2,  -7,  30,   4, -15},
		'{ -6,  13,  -1,   9,   7, -28,  16,  -4,  25,  10, -19,   3,  -8,  12,   6},
		'{ 20,   5, -14,   2,  -9,  18,   3,  11, -13,  -2,   8,  24, -17,   9,   1}
	};

	localparam logic signed [dataWidth-1:0] hiddenBias [numHidden] = '{3, -7, 12, 5};

	// output layer, one row per output neuron and one column per hidden neuron
	localparam logic signed [dataWidth-1:0] outWeights [numOutputs][numHidden] = '{
		'{ 4, -3,  2,  1},
		'{-2,  5, -1,  3}
	};

	localparam logic signed [dataWidth-1:0] outBias [numOutputs] = '{6, -4};

endpackage

`default_nettype wire
